// ==== list.f ====
source/fds_pkg.sv
source/fds_timer_regs.sv
source/fds_wave_channel.sv
source/fds_bus_combine.sv
source/fds_expansion.sv
verification/fds_tb.sv

// ==== source/fds_bus_combine.sv ====
// fds read data select between register blocks, and expansion audio mix with the apu
`default_nettype none

module fds_bus_combine (
	input  logic                        clk20,
	input  logic                        reset,
	input  logic [fds_pkg::data_w-1:0]  timer_rdata,
	input  logic                        timer_hit,
	input  logic [fds_pkg::data_w-1:0]  wave_rdata,
	input  logic                        wave_hit,
	input  logic [fds_pkg::level_w-1:0] level,
	input  logic [fds_pkg::audio_w-1:0] audio_in,
	output logic [fds_pkg::data_w-1:0]  rdata,
	output logic [fds_pkg::audio_w-1:0] audio_out
);
	import fds_pkg::*;

	logic [audio_w-1:0] exp_word;
	logic [audio_w-1:0] exp_inv;
	logic [audio_w:0]   mix_sum;

	// the two address decodes never overlap
	always_comb begin
		if (timer_hit)
			rdata = timer_rdata;
		else if (wave_hit)
			rdata = wave_rdata;
		else
			rdata = '0;
	end

	// level widened to 16 bits, top bits repeated into the low end
	assign exp_word = {1'b0, level, level[level_w-1 -: 3]};
	assign exp_inv = ~exp_word; // apu side arrives inverted too

	assign mix_sum = {1'b0, audio_in} + {1'b0, exp_inv};

	always_ff @(posedge clk20) begin
		if (reset)
			audio_out <= '0;
		else
			audio_out <= {audio_w{1'b1}} - mix_sum[audio_w:1]; // halve and flip back
	end

endmodule

`default_nettype wire

// ==== source/fds_expansion.sv ====
// fds cartridge register block top: timer and drive registers, wave channel, bus and audio mix
`default_nettype none

module fds_expansion (
	input  logic                        clk20,
	input  logic                        reset,
	input  logic                        cpu_ce,
	input  logic                        wr,
	input  logic                        rd,
	input  logic [fds_pkg::addr_w-1:0]  addr,
	input  logic [fds_pkg::data_w-1:0]  wdata,
	input  logic                        fds_busy,
	input  logic                        fds_eject,
	input  logic [fds_pkg::audio_w-1:0] audio_in,
	output logic [fds_pkg::data_w-1:0]  rdata,
	output logic                        irq,
	output logic                        mirror_vertical,
	output logic [1:0]                  diskside_auto,
	output logic [fds_pkg::audio_w-1:0] audio_out
);
	import fds_pkg::*;

	logic [data_w-1:0]  timer_rdata;
	logic               timer_hit;
	logic [data_w-1:0]  wave_rdata;
	logic               wave_hit;
	logic [level_w-1:0] level;

	fds_timer_regs timer_regs0 (
		.clk20(clk20), .reset(reset), .cpu_ce(cpu_ce),
		.wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
		.fds_busy(fds_busy), .fds_eject(fds_eject),
		.irq(irq), .mirror_vertical(mirror_vertical), .diskside_auto(diskside_auto),
		.timer_rdata(timer_rdata), .timer_hit(timer_hit)
	);

	fds_wave_channel wave0 (
		.clk20(clk20), .reset(reset), .cpu_ce(cpu_ce),
		.wr(wr), .addr(addr), .wdata(wdata),
		.level(level), .wave_rdata(wave_rdata), .wave_hit(wave_hit)
	);

	fds_bus_combine combine0 (
		.clk20(clk20), .reset(reset),
		.timer_rdata(timer_rdata), .timer_hit(timer_hit),
		.wave_rdata(wave_rdata), .wave_hit(wave_hit),
		.level(level), .audio_in(audio_in),
		.rdata(rdata), .audio_out(audio_out)
	);

endmodule

`default_nettype wire

// ==== source/fds_pkg.sv ====
// fds register block constants: bus widths, register map and fixed read values
`default_nettype none

package fds_pkg;

	// cpu bus
	localparam int addr_w = 16;
	localparam int data_w = 8;

	// audio path
	localparam int level_w = 12; // wave channel output level
	localparam int audio_w = 16; // apu and mixed sample width

	// timer and drive registers
	localparam logic [addr_w-1:0] reg_timer_lo     = 16'h4020;
	localparam logic [addr_w-1:0] reg_timer_hi     = 16'h4021;
	localparam logic [addr_w-1:0] reg_timer_ctrl   = 16'h4022;
	localparam logic [addr_w-1:0] reg_io_enable    = 16'h4023;
	localparam logic [addr_w-1:0] reg_drive_ctrl   = 16'h4025;
	localparam logic [addr_w-1:0] reg_disk_side    = 16'h4027;
	localparam logic [addr_w-1:0] reg_busy         = 16'h4029;
	localparam logic [addr_w-1:0] reg_irq_status   = 16'h4030;
	localparam logic [addr_w-1:0] reg_drive_status = 16'h4032;
	localparam logic [addr_w-1:0] reg_ext_status   = 16'h4033;

	// wave channel registers
	localparam logic [addr_w-1:0] reg_vol      = 16'h4080; // direct gain write
	localparam logic [addr_w-1:0] reg_freq_lo  = 16'h4082;
	localparam logic [addr_w-1:0] reg_freq_hi  = 16'h4083; // freq high nibble, halt
	localparam logic [addr_w-1:0] reg_master   = 16'h4089; // table write enable, master vol
	localparam logic [addr_w-1:0] reg_vol_read = 16'h4090;

	// wave table window, end is exclusive
	localparam logic [addr_w-1:0] wave_base = 16'h4040;
	localparam logic [addr_w-1:0] wave_end  = 16'h4080;

	// fixed read values
	localparam logic [data_w-1:0] ext_status_value = 8'h80; // battery good
	localparam logic [data_w-1:0] open_bus_value   = 8'h40;

	// pitch is frequency times 64 with the modulator gone
	localparam int pitch_shift = 6;

endpackage

`default_nettype wire

// ==== source/fds_timer_regs.sv ====
// fds timer irq and drive control registers, with status reads at 4029 to 4033
`default_nettype none

module fds_timer_regs (
	input  logic                       clk20,
	input  logic                       reset,
	input  logic                       cpu_ce,
	input  logic                       wr,
	input  logic                       rd,
	input  logic [fds_pkg::addr_w-1:0] addr,
	input  logic [fds_pkg::data_w-1:0] wdata,
	input  logic                       fds_busy,
	input  logic                       fds_eject,
	output logic                       irq,
	output logic                       mirror_vertical,
	output logic [1:0]                 diskside_auto,
	output logic [fds_pkg::data_w-1:0] timer_rdata,
	output logic                       timer_hit
);
	import fds_pkg::*;

	logic [15:0] timer_latch;
	logic [15:0] timer_count;
	logic        timer_armed;
	logic        timer_repeat;
	logic        io_enable;    // 4023 bit 0, gates timer start
	logic        wr_strobe;
	logic        rd_strobe;
	logic        timer_start;

	assign wr_strobe = cpu_ce & wr;
	assign rd_strobe = cpu_ce & rd;
	assign timer_start = wr_strobe && addr == reg_timer_ctrl && wdata[1] && io_enable;

	// reload value and down counter
	always_ff @(posedge clk20) begin
		if (wr_strobe && addr == reg_timer_lo)
			timer_latch[7:0] <= wdata;
		if (wr_strobe && addr == reg_timer_hi)
			timer_latch[15:8] <= wdata;

		if (timer_start) begin
			timer_count <= timer_latch;
		end else if (cpu_ce && timer_armed) begin
			if (timer_count == 16'd0)
				timer_count <= timer_latch; // wrap, repeat mode reuses it
			else
				timer_count <= timer_count - 16'd1;
		end
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			irq <= 1'b0;
			timer_armed <= 1'b0;
			timer_repeat <= 1'b0;
			io_enable <= 1'b0;
			mirror_vertical <= 1'b0;
			diskside_auto <= 2'd0;
		end else begin
			if (cpu_ce && timer_armed && timer_count == 16'd0) begin
				irq <= 1'b1;
				if (!timer_repeat)
					timer_armed <= 1'b0;
			end

			if (wr_strobe) begin
				case (addr)
					reg_timer_ctrl: begin
						timer_repeat <= wdata[0];
						timer_armed <= wdata[1] & io_enable;
						if (!(wdata[1] && io_enable))
							irq <= 1'b0;
					end
					reg_io_enable: begin
						io_enable <= wdata[0];
						if (!wdata[0]) begin
							timer_armed <= 1'b0;
							irq <= 1'b0;
						end
					end
					reg_drive_ctrl: mirror_vertical <= ~wdata[3]; // bit 3 low means vertical
					reg_disk_side:  diskside_auto <= wdata[1:0];
					default: ;
				endcase
			end

			// status read acknowledges, returned value is the pre-clear state
			if (rd_strobe && addr == reg_irq_status)
				irq <= 1'b0;
		end
	end

	always_comb begin
		timer_hit = 1'b1;
		case (addr)
			reg_busy:         timer_rdata = {{(data_w-1){1'b0}}, ~fds_busy}; // 1 = ready
			reg_irq_status:   timer_rdata = {{(data_w-1){1'b0}}, irq};
			reg_drive_status: timer_rdata = {{(data_w-3){1'b0}}, fds_eject, 1'b0, fds_eject};
			reg_ext_status:   timer_rdata = ext_status_value;
			default: begin
				timer_rdata = '0;
				timer_hit = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== source/fds_wave_channel.sv ====
// fds wavetable audio channel: 64 entry table, phase accumulator, gain and master volume
`default_nettype none

module fds_wave_channel (
	input  logic                        clk20,
	input  logic                        reset,
	input  logic                        cpu_ce,
	input  logic                        wr,
	input  logic [fds_pkg::addr_w-1:0]  addr,
	input  logic [fds_pkg::data_w-1:0]  wdata,
	output logic [fds_pkg::level_w-1:0] level,
	output logic [fds_pkg::data_w-1:0]  wave_rdata,
	output logic                        wave_hit
);
	import fds_pkg::*;

	logic [5:0]  wave_table [0:63];
	logic [23:0] wave_accum;
	logic [3:0]  cycles;      // one accumulator step per 16 strobes
	logic [11:0] wave_freq;
	logic        wave_halt;
	logic [5:0]  vol_gain;
	logic        wave_wren;   // table writable, output frozen
	logic [1:0]  master_vol;
	logic [5:0]  wave_latch;
	logic [5:0]  vol_latch;

	logic [23:0]        wave_pitch;
	logic [5:0]         wave_index;
	logic [5:0]         gain_limited;
	logic               wr_strobe;
	logic               wave_win;
	logic               reg_win;
	logic [level_w-1:0] mul_out;
	logic [level_w:0]   mul_x2;
	logic [level_w:0]   mul_third;
	logic [level_w:0]   mul_fifth;

	assign wr_strobe = cpu_ce & wr;
	assign wave_pitch = {12'd0, wave_freq} << pitch_shift;
	assign wave_index = wave_accum[23:18];
	assign gain_limited = vol_gain[5] ? 6'd32 : vol_gain; // anything past 32 acts as 32

	// table window and the audio register block 4080 to 4097
	assign wave_win = addr >= wave_base && addr < wave_end;
	assign reg_win = addr >= wave_end && addr <= reg_vol_read + 16'd7;
	assign wave_hit = wave_win | reg_win;

	always_ff @(posedge clk20) begin
		if (reset) begin
			for (int i = 0; i < 64; i++)
				wave_table[i] <= 6'd0;
		end else if (wr_strobe && wave_win && wave_wren) begin
			wave_table[addr[5:0]] <= wdata[5:0];
		end
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			wave_accum <= 24'd0;
			cycles <= 4'd0;
			wave_freq <= 12'd0;
			wave_halt <= 1'b1;
			vol_gain <= 6'd0;
			wave_wren <= 1'b0;
			master_vol <= 2'd0;
			wave_latch <= 6'd0;
			vol_latch <= 6'd0;
		end else begin
			if (cpu_ce) begin
				cycles <= wave_halt ? 4'd0 : cycles + 4'd1;
				if (!wave_halt && &cycles)
					wave_accum <= wave_accum + wave_pitch;

				// gain only takes effect at the start of a wave period
				if (wave_index == 6'd0)
					vol_latch <= gain_limited;
				if (!wave_wren)
					wave_latch <= wave_table[wave_index];
			end

			if (wr_strobe) begin
				case (addr)
					reg_vol:     vol_gain <= wdata[5:0];
					reg_freq_lo: wave_freq[7:0] <= wdata;
					reg_freq_hi: begin
						wave_freq[11:8] <= wdata[3:0];
						wave_halt <= wdata[7];
						if (wdata[7]) begin
							wave_accum <= 24'd0;
							cycles <= 4'd0;
						end
					end
					reg_master: begin
						wave_wren <= wdata[7];
						master_vol <= wdata[1:0];
					end
					default: ;
				endcase
			end
		end
	end

	// sample times volume, then master scaling
	assign mul_out = wave_latch * vol_latch;
	assign mul_x2 = {mul_out, 1'b0};
	assign mul_third = mul_x2 / 3;
	assign mul_fifth = mul_x2 / 5;

	always_comb begin
		case (master_vol)
			2'd0:    level = mul_out;
			2'd1:    level = mul_third[level_w-1:0]; // 2/3
			2'd2:    level = mul_out >> 1;
			default: level = mul_fifth[level_w-1:0]; // 2/5
		endcase
	end

	always_comb begin
		if (wave_win) begin
			if (wave_wren)
				wave_rdata = {2'b00, wave_table[addr[5:0]]};
			else
				wave_rdata = {2'b00, wave_latch};
		end else if (addr == reg_vol_read) begin
			wave_rdata = {2'b01, vol_gain};
		end else begin
			wave_rdata = open_bus_value; // envelope and modulator reads not kept
		end
	end

endmodule

`default_nettype wire

// ==== verification/fds_patterns.txt ====
# op addr data expect, all hex. op 0 write, 1 read check, 2 wait data strobes, 3 irq check,
# 4 audio check, 5 busy/eject from data, 6 audio_in, 7 {mirror,side} check, 8 level check
3 0000 0000 0000
7 0000 0000 0000
8 0000 0000 0000
4 0000 0000 8000
6 0000 1234 0000
4 0000 0000 76e6
# one-shot timer, latch 5
0 4023 0001 0000
0 4020 0005 0000
0 4021 0000 0000
0 4022 0002 0000
2 0000 0005 0000
3 0000 0000 0000
2 0000 0001 0000
3 0000 0000 0001
1 4030 0000 0001
3 0000 0000 0000
2 0000 0006 0000
3 0000 0000 0000
# repeat mode, latch 3, then disable through 4023
0 4020 0003 0000
0 4022 0003 0000
2 0000 0003 0000
3 0000 0000 0000
2 0000 0001 0000
3 0000 0000 0001
1 4030 0000 0001
3 0000 0000 0000
2 0000 0002 0000
3 0000 0000 0000
2 0000 0001 0000
3 0000 0000 0001
0 4023 0000 0000
3 0000 0000 0000
2 0000 0008 0000
1 4030 0000 0000
# drive control and status
0 4025 0000 0000
7 0000 0000 0004
0 4027 0002 0000
7 0000 0000 0006
0 4025 0008 0000
7 0000 0000 0002
5 0000 0001 0000
1 4029 0000 0000
5 0000 0002 0000
1 4029 0000 0001
1 4032 0000 0005
1 4033 0000 0080
5 0000 0000 0000
1 4032 0000 0000
# wave table under write enable, unmapped reads, gain readback
0 4089 0080 0000
0 4040 002a 0000
0 407f 0015 0000
0 4041 00ff 0000
1 4040 0000 002a
1 407f 0000 0015
1 4041 0000 003f
1 4010 0000 0000
1 4098 0000 0000
1 4095 0000 0040
0 4080 0025 0000
1 4090 0000 0065
# halted, sample 2a, gain 25 limited to 20, each master volume
0 4089 0000 0000
2 0000 0001 0000
8 0000 0000 0540
1 4045 0000 002a
4 0000 0000 8be7
0 4089 0001 0000
8 0000 0000 0380
4 0000 0000 84e6
0 4089 0002 0000
8 0000 0000 02a0
4 0000 0000 8166
0 4089 0003 0000
8 0000 0000 0219
4 0000 0000 7f4a
0 4089 0000 0000
0 4080 0010 0000
2 0000 0001 0000
8 0000 0000 02a0
4 0000 0000 8166

// ==== verification/fds_tb.sv ====
// fds register block testbench: replays the pattern file against the expansion top level
`default_nettype none

module fds_tb;
	import fds_pkg::*;

	localparam int reset_cycles = 10;
	localparam pattern_file = "verification/fds_patterns.txt";

	logic               clk20 = 1'b0;
	logic               reset;
	logic               cpu_ce;
	logic               wr;
	logic               rd;
	logic [addr_w-1:0]  addr;
	logic [data_w-1:0]  wdata;
	logic               fds_busy;
	logic               fds_eject;
	logic [audio_w-1:0] audio_in;
	logic [data_w-1:0]  rdata;
	logic               irq;
	logic               mirror_vertical;
	logic [1:0]         diskside_auto;
	logic [audio_w-1:0] audio_out;

	logic [3:0]  pat_op [$];
	logic [15:0] pat_addr [$];
	logic [15:0] pat_data [$];
	logic [15:0] pat_expect [$];
	int errors = 0;
	int checks = 0;
	int cycle_count = 0;
	int cycle_limit = 1000; // replaced once the pattern file is loaded

	always #20 clk20 = ~clk20;

	fds_expansion dut0 (
		.clk20(clk20), .reset(reset), .cpu_ce(cpu_ce),
		.wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
		.fds_busy(fds_busy), .fds_eject(fds_eject), .audio_in(audio_in),
		.rdata(rdata), .irq(irq), .mirror_vertical(mirror_vertical),
		.diskside_auto(diskside_auto), .audio_out(audio_out)
	);

	always @(posedge clk20) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: run still busy after %0d clock cycles", cycle_limit);
			$display("Regression failed");
			$finish;
		end
	end

	// fields are hex: op addr data expect, lines starting with # are skipped
	task automatic load_patterns(output int wait_total);
		int fd;
		int n;
		string line;
		logic [15:0] f_op;
		logic [15:0] f_addr;
		logic [15:0] f_data;
		logic [15:0] f_exp;
		wait_total = 0;
		fd = $fopen(pattern_file, "r");
		if (fd == 0) begin
			$display("could not open pattern file %s", pattern_file);
			errors++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n <= 0 || line[0] == "#")
				continue;
			n = $sscanf(line, "%h %h %h %h", f_op, f_addr, f_data, f_exp);
			if (n == 4) begin
				pat_op.push_back(f_op[3:0]);
				pat_addr.push_back(f_addr);
				pat_data.push_back(f_data);
				pat_expect.push_back(f_exp);
				if (f_op == 16'h2)
					wait_total += f_data;
			end else if (n > 0) begin
				$display("pattern line could not be read: %s", line);
				errors++;
			end
		end
		$fclose(fd);
	endtask

	// one cpu cycle, strobe high for a single clk20 edge then three idle clocks
	task automatic bus_cycle(input logic do_wr, input logic do_rd, input logic [15:0] a,
			input logic [7:0] d, output logic [7:0] seen);
		cpu_ce = 1'b1;
		wr = do_wr;
		rd = do_rd;
		addr = a;
		wdata = d;
		#10 seen = rdata; // mid low phase, before the strobe edge
		@(negedge clk20);
		cpu_ce = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		repeat (3) @(negedge clk20);
	endtask

	task automatic check_value(input string what, input logic [15:0] got,
			input logic [15:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic run_op(input logic [3:0] op, input logic [15:0] a, input logic [15:0] d,
			input logic [15:0] exp);
		logic [7:0] seen;
		case (op)
			4'h0: bus_cycle(1'b1, 1'b0, a, d[7:0], seen);
			4'h1: begin
				bus_cycle(1'b0, 1'b1, a, 8'h00, seen);
				check_value($sformatf("read of %h", a), {8'h00, seen}, exp);
			end
			4'h2: repeat (d) bus_cycle(1'b0, 1'b0, 16'h0000, 8'h00, seen);
			4'h3: check_value("irq", {15'd0, irq}, exp);
			4'h4: begin
				@(negedge clk20); // registered mix, one clock behind
				check_value("audio_out", audio_out, exp);
			end
			4'h5: begin
				fds_busy = d[0];
				fds_eject = d[1];
			end
			4'h6: audio_in = d;
			4'h7: check_value("mirror and disk side", {13'd0, mirror_vertical, diskside_auto}, exp);
			4'h8: check_value("wave level", {4'd0, dut0.wave0.level}, exp);
			default: begin
				errors++;
				$display("unknown operation %h in pattern file", op);
			end
		endcase
	endtask

	initial begin
		int wait_total;
		reset = 1'b1;
		cpu_ce = 1'b0;
		wr = 1'b0;
		rd = 1'b0;
		addr = '0;
		wdata = '0;
		fds_busy = 1'b0;
		fds_eject = 1'b0;
		audio_in = '0;
		load_patterns(wait_total);
		if (pat_op.size() == 0) begin
			$display("pattern file holds no operations");
			errors++;
		end
		// every op or waited strobe takes four clocks at most
		cycle_limit = reset_cycles + 20 + 5 * (pat_op.size() + wait_total);

		repeat (reset_cycles) @(negedge clk20);
		reset = 1'b0;

		foreach (pat_op[i])
			run_op(pat_op[i], pat_addr[i], pat_data[i], pat_expect[i]);

		$display("checks: %0d  errors: %0d", checks, errors);
		if (errors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire
